//--- verilog/rv_config.svh
`ifndef RV_CONFIG_SVH
`define RV_CONFIG_SVH

// data path and address width
`define RV_XLEN 32

// architectural registers, x0 included
`define RV_REG_COUNT 32

// first fetch address out of reset
`define RV_RESET_PC 32'h0000_0000

// sequential fetch distance in bytes
`define RV_PC_STEP 32'd4

`endif

//--- verilog/rv_pkg.sv
`include "rv_config.svh"

package rv_pkg;

  typedef logic [`RV_XLEN-1:0] word_t;
  typedef logic [$clog2(`RV_REG_COUNT)-1:0] reg_addr_t;
  typedef logic [$clog2(`RV_XLEN)-1:0] shamt_t;

  // major opcodes still handled by the core
  typedef enum logic [6:0] {
    OP_LUI    = 7'b0110111,
    OP_AUIPC  = 7'b0010111,
    OP_BRANCH = 7'b1100011,
    OP_IMM    = 7'b0010011,
    OP_REG    = 7'b0110011,
    OP_SYSTEM = 7'b1110011
  } opcode_e;

  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_SLL,
    ALU_SLT,
    ALU_SLTU,
    ALU_XOR,
    ALU_SRL,
    ALU_SRA,
    ALU_OR,
    ALU_AND,
    ALU_PASS_B  // lui
  } alu_op_e;

  typedef enum logic [2:0] {
    BR_NONE,
    BR_EQ,
    BR_NE,
    BR_LT,
    BR_GE,
    BR_LTU,
    BR_GEU
  } branch_cond_e;

  typedef enum logic {
    ST_RUN,
    ST_HALTED
  } core_state_e;

endpackage

//--- verilog/rv_decoder.sv
module rv_decoder (
  input  rv_pkg::word_t        insn,
  output rv_pkg::alu_op_e      alu_op,
  output logic                 use_pc_a,
  output logic                 use_imm_b,
  output rv_pkg::word_t        imm,
  output rv_pkg::reg_addr_t    rd,
  output rv_pkg::reg_addr_t    rs1,
  output rv_pkg::reg_addr_t    rs2,
  output logic                 rd_we,
  output rv_pkg::branch_cond_e branch_cond,
  output logic                 ecall
);

  rv_pkg::opcode_e opcode;
  logic [2:0]      funct3;
  logic [6:0]      funct7;
  rv_pkg::word_t   imm_i;
  rv_pkg::word_t   imm_b;
  rv_pkg::word_t   imm_u;
  logic            shift_imm;
  logic            reg_legal;
  logic            imm_legal;

  assign opcode = rv_pkg::opcode_e'(insn[6:0]);
  assign funct3 = insn[14:12];
  assign funct7 = insn[31:25];
  assign rd     = insn[11:7];
  assign rs1    = insn[19:15];
  assign rs2    = insn[24:20];

  assign imm_i = {{20{insn[31]}}, insn[31:20]};
  assign imm_b = {{19{insn[31]}}, insn[31], insn[7], insn[30:25], insn[11:8], 1'b0};
  assign imm_u = {insn[31:12], 12'h000};

  // funct7 only distinguishes add/sub and srl/sra
  assign reg_legal = (funct7 == 7'b0000000) ||
                     (funct7 == 7'b0100000 && (funct3 == 3'b000 || funct3 == 3'b101));

  assign shift_imm = (funct3 == 3'b001) || (funct3 == 3'b101);
  assign imm_legal = !shift_imm || (funct7 == 7'b0000000) ||
                     (funct3 == 3'b101 && funct7 == 7'b0100000);

  // shared by reg-reg and reg-imm forms
  function automatic rv_pkg::alu_op_e arith_op(input logic [2:0] f3, input logic alt);
    case (f3)
      3'b000:  arith_op = alt ? rv_pkg::ALU_SUB : rv_pkg::ALU_ADD;
      3'b001:  arith_op = rv_pkg::ALU_SLL;
      3'b010:  arith_op = rv_pkg::ALU_SLT;
      3'b011:  arith_op = rv_pkg::ALU_SLTU;
      3'b100:  arith_op = rv_pkg::ALU_XOR;
      3'b101:  arith_op = alt ? rv_pkg::ALU_SRA : rv_pkg::ALU_SRL;
      3'b110:  arith_op = rv_pkg::ALU_OR;
      default: arith_op = rv_pkg::ALU_AND;
    endcase
  endfunction

  always_comb begin
    alu_op      = rv_pkg::ALU_ADD;
    use_pc_a    = 1'b0;
    use_imm_b   = 1'b0;
    imm         = imm_i;
    rd_we       = 1'b0;
    branch_cond = rv_pkg::BR_NONE;
    ecall       = 1'b0;

    case (opcode)
      rv_pkg::OP_LUI: begin
        alu_op    = rv_pkg::ALU_PASS_B;
        use_imm_b = 1'b1;
        imm       = imm_u;
        rd_we     = 1'b1;
      end
      rv_pkg::OP_AUIPC: begin
        use_pc_a  = 1'b1;  // pc + upper immediate
        use_imm_b = 1'b1;
        imm       = imm_u;
        rd_we     = 1'b1;
      end
      rv_pkg::OP_IMM: begin
        use_imm_b = 1'b1;  // shamt sits in imm_i[4:0]
        alu_op    = arith_op(funct3, shift_imm & funct7[5]);
        rd_we     = imm_legal;
      end
      rv_pkg::OP_REG: begin
        alu_op = arith_op(funct3, funct7[5]);
        rd_we  = reg_legal;
      end
      rv_pkg::OP_BRANCH: begin
        imm = imm_b;  // offset for the fetch unit
        case (funct3)
          3'b000:  branch_cond = rv_pkg::BR_EQ;
          3'b001:  branch_cond = rv_pkg::BR_NE;
          3'b100:  branch_cond = rv_pkg::BR_LT;
          3'b101:  branch_cond = rv_pkg::BR_GE;
          3'b110:  branch_cond = rv_pkg::BR_LTU;
          3'b111:  branch_cond = rv_pkg::BR_GEU;
          default: branch_cond = rv_pkg::BR_NONE;
        endcase
      end
      rv_pkg::OP_SYSTEM: begin
        ecall = (insn[31:7] == 25'd0);
      end
      default: begin
        // anything else retires as a no-op
      end
    endcase
  end

endmodule

//--- verilog/rv_alu.sv
module rv_alu (
  input  rv_pkg::alu_op_e alu_op,
  input  rv_pkg::word_t   a,
  input  rv_pkg::word_t   b,
  output rv_pkg::word_t   result
);

  rv_pkg::shamt_t shamt;
  logic           lt_signed;
  logic           lt_unsigned;

  assign shamt       = b[4:0];  // upper bits of b ignored for shifts
  assign lt_signed   = $signed(a) < $signed(b);
  assign lt_unsigned = a < b;

  always_comb begin
    case (alu_op)
      rv_pkg::ALU_ADD: begin
        result = a + b;
      end
      rv_pkg::ALU_SUB: begin
        result = a - b;
      end
      rv_pkg::ALU_SLL: begin
        result = a << shamt;
      end
      rv_pkg::ALU_SLT: begin
        result = rv_pkg::word_t'(lt_signed);  // 1 or 0
      end
      rv_pkg::ALU_SLTU: begin
        result = rv_pkg::word_t'(lt_unsigned);
      end
      rv_pkg::ALU_XOR: begin
        result = a ^ b;
      end
      rv_pkg::ALU_SRL: begin
        result = a >> shamt;
      end
      rv_pkg::ALU_SRA: begin
        result = rv_pkg::word_t'($signed(a) >>> shamt);
      end
      rv_pkg::ALU_OR: begin
        result = a | b;
      end
      rv_pkg::ALU_AND: begin
        result = a & b;
      end
      rv_pkg::ALU_PASS_B: begin
        result = b;
      end
      default: begin
        result = '0;
      end
    endcase
  end

endmodule

//--- verilog/rv_regfile.sv
`include "rv_config.svh"

module rv_regfile (
  input  logic              clk,
  input  logic              rst,
  input  logic              we,
  input  rv_pkg::reg_addr_t rd,
  input  rv_pkg::reg_addr_t rs1,
  input  rv_pkg::reg_addr_t rs2,
  input  rv_pkg::word_t     rd_data,
  output rv_pkg::word_t     rs1_data,
  output rv_pkg::word_t     rs2_data
);

  // x0 has no storage
  rv_pkg::word_t regs [1:`RV_REG_COUNT-1];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 1; i < `RV_REG_COUNT; i++) begin
        regs[i] <= '0;
      end
    end else if (we && rd != '0) begin
      regs[rd] <= rd_data;
    end
  end

  // combinational reads with x0 forced to zero
  assign rs1_data = (rs1 == '0) ? '0 : regs[rs1];
  assign rs2_data = (rs2 == '0) ? '0 : regs[rs2];

endmodule

//--- verilog/rv_fetch_ctrl.sv
`include "rv_config.svh"

module rv_fetch_ctrl (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 accept,
  input  logic                 ecall,
  input  rv_pkg::branch_cond_e branch_cond,
  input  rv_pkg::word_t        rs1_data,
  input  rv_pkg::word_t        rs2_data,
  input  rv_pkg::word_t        imm,
  output rv_pkg::word_t        pc,
  output logic                 halt
);

  rv_pkg::core_state_e state;
  rv_pkg::word_t       next_pc;
  logic                taken;

  // branch resolution on the register operands
  always_comb begin
    case (branch_cond)
      rv_pkg::BR_EQ:  taken = rs1_data == rs2_data;
      rv_pkg::BR_NE:  taken = rs1_data != rs2_data;
      rv_pkg::BR_LT:  taken = $signed(rs1_data) < $signed(rs2_data);
      rv_pkg::BR_GE:  taken = $signed(rs1_data) >= $signed(rs2_data);
      rv_pkg::BR_LTU: taken = rs1_data < rs2_data;
      rv_pkg::BR_GEU: taken = rs1_data >= rs2_data;
      default:        taken = 1'b0;  // not a branch
    endcase
  end

  assign next_pc = taken ? pc + imm : pc + rv_pkg::word_t'(`RV_PC_STEP);

  always_ff @(posedge clk) begin
    if (rst) begin
      pc    <= rv_pkg::word_t'(`RV_RESET_PC);
      state <= rv_pkg::ST_RUN;
    end else if (accept) begin
      pc <= next_pc;
      if (ecall) begin
        state <= rv_pkg::ST_HALTED;  // left only through reset
      end
    end
  end

  assign halt = (state == rv_pkg::ST_HALTED);

endmodule

//--- verilog/rv_core.sv
module rv_core (
  input  logic              clk,
  input  logic              rst,
  output rv_pkg::word_t     pc,
  input  rv_pkg::word_t     insn,
  input  logic              insn_valid,
  output logic              halt,
  output logic              retire_valid,
  output logic              retire_we,
  output rv_pkg::reg_addr_t retire_rd,
  output rv_pkg::word_t     retire_pc,
  output rv_pkg::word_t     retire_data
);

  rv_pkg::alu_op_e      alu_op;
  rv_pkg::branch_cond_e branch_cond;
  rv_pkg::word_t        imm;
  rv_pkg::word_t        rs1_data;
  rv_pkg::word_t        rs2_data;
  rv_pkg::word_t        alu_a;
  rv_pkg::word_t        alu_b;
  rv_pkg::word_t        alu_result;
  rv_pkg::reg_addr_t    rd;
  rv_pkg::reg_addr_t    rs1;
  rv_pkg::reg_addr_t    rs2;
  logic                 use_pc_a;
  logic                 use_imm_b;
  logic                 rd_we;
  logic                 ecall;
  logic                 accept;
  logic                 wr_en;

  // only halt stops fetch
  assign accept = insn_valid && !halt;

  rv_decoder u_decoder (
    .insn        (insn),
    .alu_op      (alu_op),
    .use_pc_a    (use_pc_a),
    .use_imm_b   (use_imm_b),
    .imm         (imm),
    .rd          (rd),
    .rs1         (rs1),
    .rs2         (rs2),
    .rd_we       (rd_we),
    .branch_cond (branch_cond),
    .ecall       (ecall)
  );

  rv_regfile u_regfile (
    .clk      (clk),
    .rst      (rst),
    .we       (wr_en),
    .rd       (rd),
    .rs1      (rs1),
    .rs2      (rs2),
    .rd_data  (alu_result),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data)
  );

  assign alu_a = use_pc_a ? pc : rs1_data;    // auipc
  assign alu_b = use_imm_b ? imm : rs2_data;

  rv_alu u_alu (
    .alu_op (alu_op),
    .a      (alu_a),
    .b      (alu_b),
    .result (alu_result)
  );

  rv_fetch_ctrl u_fetch_ctrl (
    .clk         (clk),
    .rst         (rst),
    .accept      (accept),
    .ecall       (ecall),
    .branch_cond (branch_cond),
    .rs1_data    (rs1_data),
    .rs2_data    (rs2_data),
    .imm         (imm),
    .pc          (pc),
    .halt        (halt)
  );

  // x0 destinations never count as writes
  assign wr_en = accept && rd_we && (rd != '0);

  assign retire_valid = accept;
  assign retire_we    = wr_en;
  assign retire_rd    = rd;
  assign retire_pc    = pc;
  assign retire_data  = alu_result;

endmodule

//--- sim/rv_core_properties.sv
module rv_core_properties (
  input logic              clk,
  input logic              rst,
  input logic              halt,
  input logic              insn_valid,
  input rv_pkg::word_t     pc,
  input logic              retire_we,
  input rv_pkg::reg_addr_t retire_rd
);
  timeunit 1ns;
  timeprecision 1ps;

  // halted state is left only through reset
  halt_sticky: assert property (
    @(posedge clk) disable iff (rst) halt |=> halt
  ) else $error("halt fell without reset");

  // no accept means no pc update
  pc_hold: assert property (
    @(posedge clk) disable iff (rst) !insn_valid |=> $stable(pc)
  ) else $error("pc moved while insn_valid was low");

  no_x0_write: assert property (
    @(posedge clk) disable iff (rst) retire_we |-> (retire_rd != '0)
  ) else $error("retire_we reported for x0");

endmodule

//--- sim/rv_core_tb.sv
`include "rv_config.svh"

module rv_core_tb;
  timeunit 1ns;
  timeprecision 1ps;

  logic                  clk = 1'b0;
  logic                  rst = 1'b1;
  logic                  insn_valid = 1'b0;
  rv_pkg::word_t         insn;
  rv_pkg::word_t         pc;
  logic                  halt;
  logic                  retire_valid;
  logic                  retire_we;
  rv_pkg::reg_addr_t     retire_rd;
  rv_pkg::word_t         retire_pc;
  rv_pkg::word_t         retire_data;

  rv_pkg::word_t         prog [0:63];  // 64-word program memory
  logic [31:0]           lfsr = 32'hcfa9_7d41;
  int                    cycle_count = 0;
  int                    error_count = 0;
  int                    check_count = 0;
  logic                  table_ready = 1'b0;

  // expected retire trace with one entry per accepted instruction
  string                 row_name [$];
  rv_pkg::word_t         row_pc [$];
  rv_pkg::word_t         row_insn [$];
  logic                  row_we [$];
  rv_pkg::reg_addr_t     row_rd [$];
  rv_pkg::word_t         row_data [$];

  rv_core dut (
    .clk          (clk),
    .rst          (rst),
    .pc           (pc),
    .insn         (insn),
    .insn_valid   (insn_valid),
    .halt         (halt),
    .retire_valid (retire_valid),
    .retire_we    (retire_we),
    .retire_rd    (retire_rd),
    .retire_pc    (retire_pc),
    .retire_data  (retire_data)
  );

  bind rv_core rv_core_properties u_props (
    .clk        (clk),
    .rst        (rst),
    .halt       (halt),
    .insn_valid (insn_valid),
    .pc         (pc),
    .retire_we  (retire_we),
    .retire_rd  (retire_rd)
  );

  assign insn = prog[pc[7:2]];

  always #4 clk = ~clk;  // 8 ns period

  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    logic fb;
    fb = s[31] ^ s[21] ^ s[1] ^ s[0];  // x^32 + x^22 + x^2 + x + 1
    lfsr_next = {s[30:0], fb};
  endfunction

  function automatic rv_pkg::word_t reg_op(input logic [6:0] f7, input logic [4:0] rs2,
                                           input logic [4:0] rs1, input logic [2:0] f3,
                                           input logic [4:0] rd);
    reg_op = {f7, rs2, rs1, f3, rd, 7'b0110011};
  endfunction

  function automatic rv_pkg::word_t imm_op(input logic [11:0] imm, input logic [4:0] rs1,
                                           input logic [2:0] f3, input logic [4:0] rd);
    imm_op = {imm, rs1, f3, rd, 7'b0010011};
  endfunction

  function automatic rv_pkg::word_t upper_op(input logic [19:0] imm, input logic [4:0] rd,
                                             input logic [6:0] opcode);
    upper_op = {imm, rd, opcode};
  endfunction

  function automatic rv_pkg::word_t branch_op(input logic [12:0] off, input logic [4:0] rs2,
                                              input logic [4:0] rs1, input logic [2:0] f3);
    branch_op = {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'b1100011};
  endfunction

  task automatic add_row(input string name, input rv_pkg::word_t at_pc,
                         input rv_pkg::word_t word, input logic we,
                         input rv_pkg::reg_addr_t rd, input rv_pkg::word_t data);
    row_name.push_back(name);
    row_pc.push_back(at_pc);
    row_insn.push_back(word);
    row_we.push_back(we);
    row_rd.push_back(rd);
    row_data.push_back(data);
  endtask

  // x1 = 5 and x2 = -3 feed most of the later rows
  task automatic build_table();
    add_row("addi_pos", 32'h00, imm_op(12'd5, 5'd0, 3'b000, 5'd1), 1'b1, 5'd1, 32'h5);
    add_row("addi_neg", 32'h04, imm_op(12'hFFD, 5'd0, 3'b000, 5'd2), 1'b1, 5'd2, 32'hFFFF_FFFD);
    add_row("lui", 32'h08, upper_op(20'h12345, 5'd3, 7'b0110111), 1'b1, 5'd3, 32'h1234_5000);
    add_row("auipc", 32'h0C, upper_op(20'h00001, 5'd4, 7'b0010111), 1'b1, 5'd4, 32'h0000_100C);
    add_row("add", 32'h10, reg_op(7'h00, 5'd2, 5'd1, 3'b000, 5'd5), 1'b1, 5'd5, 32'h2);
    add_row("sub", 32'h14, reg_op(7'h20, 5'd2, 5'd1, 3'b000, 5'd6), 1'b1, 5'd6, 32'h8);
    add_row("xor", 32'h18, reg_op(7'h00, 5'd2, 5'd1, 3'b100, 5'd7), 1'b1, 5'd7, 32'hFFFF_FFF8);
    add_row("or", 32'h1C, reg_op(7'h00, 5'd2, 5'd1, 3'b110, 5'd8), 1'b1, 5'd8, 32'hFFFF_FFFD);
    add_row("and", 32'h20, reg_op(7'h00, 5'd2, 5'd1, 3'b111, 5'd9), 1'b1, 5'd9, 32'h5);
    add_row("sll", 32'h24, reg_op(7'h00, 5'd1, 5'd3, 3'b001, 5'd10), 1'b1, 5'd10, 32'h468A_0000);
    add_row("srl", 32'h28, reg_op(7'h00, 5'd1, 5'd2, 3'b101, 5'd11), 1'b1, 5'd11, 32'h07FF_FFFF);
    add_row("sra", 32'h2C, reg_op(7'h20, 5'd1, 5'd2, 3'b101, 5'd12), 1'b1, 5'd12, 32'hFFFF_FFFF);
    add_row("slt", 32'h30, reg_op(7'h00, 5'd1, 5'd2, 3'b010, 5'd13), 1'b1, 5'd13, 32'h1);
    add_row("sltu", 32'h34, reg_op(7'h00, 5'd1, 5'd2, 3'b011, 5'd14), 1'b1, 5'd14, 32'h0);
    add_row("slti", 32'h38, imm_op(12'hFFE, 5'd2, 3'b010, 5'd15), 1'b1, 5'd15, 32'h1);
    add_row("sltiu", 32'h3C, imm_op(12'hFFF, 5'd1, 3'b011, 5'd16), 1'b1, 5'd16, 32'h1);
    add_row("xori", 32'h40, imm_op(12'h0F0, 5'd1, 3'b100, 5'd17), 1'b1, 5'd17, 32'hF5);
    add_row("ori", 32'h44, imm_op(12'hFF0, 5'd1, 3'b110, 5'd18), 1'b1, 5'd18, 32'hFFFF_FFF5);
    add_row("andi", 32'h48, imm_op(12'h07F, 5'd2, 3'b111, 5'd19), 1'b1, 5'd19, 32'h7D);
    add_row("slli", 32'h4C, imm_op({7'h00, 5'd28}, 5'd1, 3'b001, 5'd20), 1'b1, 5'd20,
            32'h5000_0000);
    add_row("srli", 32'h50, imm_op({7'h00, 5'd28}, 5'd2, 3'b101, 5'd21), 1'b1, 5'd21, 32'hF);
    add_row("srai", 32'h54, imm_op({7'h20, 5'd1}, 5'd2, 3'b101, 5'd22), 1'b1, 5'd22,
            32'hFFFF_FFFE);
    add_row("addi_x0", 32'h58, imm_op(12'd7, 5'd1, 3'b000, 5'd0), 1'b0, 5'd0, 32'h0);
    add_row("add_from_x0", 32'h5C, reg_op(7'h00, 5'd1, 5'd0, 3'b000, 5'd23), 1'b1, 5'd23, 32'h5);
    // taken branches skip one word so their successor sits at pc + 8
    add_row("beq_taken", 32'h60, branch_op(13'd8, 5'd1, 5'd1, 3'b000), 1'b0, 5'd0, 32'h0);
    add_row("beq_not", 32'h68, branch_op(13'd8, 5'd2, 5'd1, 3'b000), 1'b0, 5'd0, 32'h0);
    add_row("bne_taken", 32'h6C, branch_op(13'd8, 5'd2, 5'd1, 3'b001), 1'b0, 5'd0, 32'h0);
    add_row("bne_not", 32'h74, branch_op(13'd8, 5'd1, 5'd1, 3'b001), 1'b0, 5'd0, 32'h0);
    add_row("blt_taken", 32'h78, branch_op(13'd8, 5'd1, 5'd2, 3'b100), 1'b0, 5'd0, 32'h0);
    add_row("blt_not", 32'h80, branch_op(13'd8, 5'd2, 5'd1, 3'b100), 1'b0, 5'd0, 32'h0);
    add_row("bge_taken", 32'h84, branch_op(13'd8, 5'd2, 5'd1, 3'b101), 1'b0, 5'd0, 32'h0);
    add_row("bge_not", 32'h8C, branch_op(13'd8, 5'd1, 5'd2, 3'b101), 1'b0, 5'd0, 32'h0);
    add_row("bltu_taken", 32'h90, branch_op(13'd8, 5'd2, 5'd1, 3'b110), 1'b0, 5'd0, 32'h0);
    add_row("bltu_not", 32'h98, branch_op(13'd8, 5'd1, 5'd2, 3'b110), 1'b0, 5'd0, 32'h0);
    add_row("bgeu_taken", 32'h9C, branch_op(13'd8, 5'd1, 5'd2, 3'b111), 1'b0, 5'd0, 32'h0);
    add_row("bgeu_not", 32'hA4, branch_op(13'd8, 5'd2, 5'd1, 3'b111), 1'b0, 5'd0, 32'h0);
    add_row("addi_after", 32'hA8, imm_op(12'd1, 5'd23, 3'b000, 5'd24), 1'b1, 5'd24, 32'h6);
    add_row("ecall", 32'hAC, 32'h0000_0073, 1'b0, 5'd0, 32'h0);
  endtask

  task automatic check_row(input int k);
    check_count++;
    if (retire_pc !== row_pc[k]) begin
      error_count++;
      $display("** Error [%s] retire_pc: expected %h, actual %h", row_name[k], row_pc[k],
               retire_pc);
    end
    if (retire_we !== row_we[k]) begin
      error_count++;
      $display("** Error [%s] retire_we: expected %b, actual %b", row_name[k], row_we[k],
               retire_we);
    end
    if (row_we[k]) begin
      if (retire_rd !== row_rd[k]) begin
        error_count++;
        $display("** Error [%s] retire_rd: expected %0d, actual %0d", row_name[k], row_rd[k],
                 retire_rd);
      end
      if (retire_data !== row_data[k]) begin
        error_count++;
        $display("** Error [%s] retire_data: expected %h, actual %h", row_name[k],
                 row_data[k], retire_data);
      end
    end
  endtask

  // reset and insn_valid change 1 ns after the rising edge
  always @(posedge clk) begin
    #1;
    cycle_count++;
    rst = (cycle_count < 3);
    if (rst) begin
      insn_valid = 1'b0;
    end else begin
      lfsr = lfsr_next(lfsr);
      insn_valid = !lfsr[0];
      lfsr = lfsr_next(lfsr);
      insn_valid = insn_valid || !lfsr[0];  // low when both bits are set
    end
  end

  initial begin
    for (int i = 0; i < 64; i++) begin
      prog[i] = {20'(i), 5'd31, 7'b0110111};  // lui x31 poison that never retires
    end
    build_table();
    for (int k = 0; k < row_pc.size(); k++) begin
      prog[row_pc[k][7:2]] = row_insn[k];
    end
    table_ready = 1'b1;

    @(negedge clk);
    while (rst) begin
      check_count++;
      if (pc !== `RV_RESET_PC || halt !== 1'b0 || retire_valid !== 1'b0) begin
        error_count++;
        $display("reset state wrong: pc %h, halt %b, retire_valid %b", pc, halt, retire_valid);
      end
      @(negedge clk);
    end

    for (int k = 0; k < row_pc.size(); k++) begin
      while (retire_valid !== 1'b1) begin
        @(negedge clk);
      end
      check_row(k);
      @(negedge clk);
    end

    // once halted pc stays one step past the ecall and nothing more retires
    repeat (16) begin
      check_count++;
      if (halt !== 1'b1 || retire_valid !== 1'b0 || pc !== 32'h0000_00B0) begin
        error_count++;
        $display("core still active after ecall: halt %b, retire_valid %b, pc %h",
                 halt, retire_valid, pc);
      end
      @(negedge clk);
    end

    $display("errors: %0d, checks: %0d", error_count, check_count);
    if (error_count == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

  // watchdog allows twice the table length times four cycles
  initial begin
    int limit_cycles;
    wait (table_ready);
    limit_cycles = 2 * row_pc.size() * 4;
    repeat (limit_cycles) @(posedge clk);
    $display("timeout: retire trace not finished after %0d cycles, errors so far %0d",
             limit_cycles, error_count);
    $display("SIMULATION FAILED");
    $finish;
  end

endmodule

//--- project.f
+incdir+verilog
verilog/rv_pkg.sv
verilog/rv_decoder.sv
verilog/rv_alu.sv
verilog/rv_regfile.sv
verilog/rv_fetch_ctrl.sv
verilog/rv_core.sv
sim/rv_core_properties.sv
sim/rv_core_tb.sv

//--- run_sim.sh
#!/bin/sh
# build and run the rv_core testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
  --top-module rv_core_tb -Mdir obj_dir -f project.f
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

output=$(./obj_dir/Vrv_core_tb)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$output" | grep -q "^SIMULATION PASSED$"; then
  exit 0
else
  exit 1
fi
